// ==== dcache_axi_pkg.sv ====
`default_nettype none

package dcache_axi_pkg;

    localparam int ADDR_WIDTH = 64;
    localparam int DATA_WIDTH = 64;                     // one AXI beat
    localparam int LINE_WIDTH = 256;                    // one cache line
    localparam int BEATS      = LINE_WIDTH / DATA_WIDTH;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int ID_WIDTH   = 4;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // unprivileged, secure, data access
    localparam logic [2:0] AXI_PROT_DATA = 3'b000;

    typedef logic [LINE_WIDTH-1:0] line_t;

    // address channel payload, same layout for AR and AW
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;     // beats minus one
        logic [2:0]            size;    // log2 of bytes per beat
        logic [1:0]            burst;
        logic [2:0]            prot;
        logic [ID_WIDTH-1:0]   id;
    } ar_req_t;

    typedef ar_req_t aw_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } w_beat_t;

    // resp is not carried, the bridge never looks at it
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } r_beat_t;

endpackage

`default_nettype wire

// ==== dcache_axi_rd.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_axi_rd
    import dcache_axi_pkg::*;
#(
    parameter logic [ID_WIDTH-1:0] AXI_ID = '0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [1:0]            len_i,
    input  logic [2:0]            size_i,
    output logic                  ready_o,
    output ar_req_t               ar_o,
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    input  r_beat_t               r_i,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    output r_beat_t               beat_o,
    output logic                  beat_valid_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,     // AR up until arready
        S_DATA      // collecting R beats
    } state_t;

    state_t state_q, state_d;

    logic [ADDR_WIDTH-1:0] addr_q;
    logic [1:0]            len_q;
    logic [2:0]            size_q;

    logic accept;
    logic ar_fire;
    logic r_fire;

    assign accept  = (state_q == S_IDLE) && req_i;
    assign ar_fire = ar_valid_o && ar_ready_i;
    assign r_fire  = r_valid_i && r_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_i) begin
                    state_d = S_ADDR;
                end
            end
            S_ADDR: begin
                if (ar_fire) begin
                    state_d = S_DATA;
                end
            end
            S_DATA: begin
                if (r_fire && r_i.last) begin   // last alone is not enough
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q <= addr_i;
            len_q  <= len_i;
            size_q <= size_i;
        end
    end

    assign ready_o    = (state_q == S_IDLE);
    assign ar_valid_o = (state_q == S_ADDR);
    assign r_ready_o  = (state_q == S_DATA);

    assign ar_o.addr  = addr_q;
    assign ar_o.len   = {6'd0, len_q};
    assign ar_o.size  = size_q;
    assign ar_o.burst = AXI_BURST_INCR;
    assign ar_o.prot  = AXI_PROT_DATA;
    assign ar_o.id    = AXI_ID;

    // beats go straight to the refill buffer on each handshake
    assign beat_o       = r_i;
    assign beat_valid_o = r_fire;

    // AR held with a stable payload until the slave takes it
    assert property (@(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

    // the slave offers R beats only while a burst is open
    assert property (@(posedge clock) disable iff (!reset)
        r_valid_i |-> state_q == S_DATA);

endmodule

`default_nettype wire

// ==== dcache_refill_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_refill_buf
    import dcache_axi_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  r_beat_t beat_i,
    input  logic    beat_valid_i,
    output line_t   line_o,
    output logic    line_valid_o
);

    localparam int IDX_WIDTH = $clog2(BEATS);

    logic [IDX_WIDTH-1:0] idx_q;    // slot for the next beat
    line_t                line_q;
    logic                 line_valid_q;

    // beat index, back to slot 0 once the burst ends
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            idx_q <= '0;
        end else if (beat_valid_i) begin
            if (beat_i.last) begin
                idx_q <= '0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // slots a short burst does not reach keep what they had
    always_ff @(posedge clock) begin
        if (beat_valid_i) begin
            line_q[idx_q*DATA_WIDTH +: DATA_WIDTH] <= beat_i.data;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= beat_valid_i && beat_i.last;   // one cycle only
        end
    end

    assign line_o       = line_q;
    assign line_valid_o = line_valid_q;

    // a burst longer than a line would wrap onto slot 0
    assert property (@(posedge clock) disable iff (!reset)
        beat_valid_i && idx_q == IDX_WIDTH'(BEATS - 1) |-> beat_i.last);

    // the pulse never stretches, the read path needs a new AR first
    assert property (@(posedge clock) disable iff (!reset)
        line_valid_o |=> !line_valid_o);

endmodule

`default_nettype wire

// ==== dcache_axi_wr.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_axi_wr
    import dcache_axi_pkg::*;
#(
    parameter logic [ID_WIDTH-1:0] AXI_ID = '0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  line_t                 line_i,
    input  logic [STRB_WIDTH-1:0] mask_i,
    input  logic [1:0]            len_i,
    input  logic [2:0]            size_i,
    output logic                  ready_o,
    output aw_req_t               aw_o,
    output logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    output w_beat_t               w_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    input  logic                  b_valid_i,
    output logic                  b_ready_o
);

    localparam int CNT_WIDTH = $clog2(BEATS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP      // waiting for B
    } state_t;

    state_t state_q, state_d;

    logic [ADDR_WIDTH-1:0] addr_q;
    line_t                 line_q;
    logic [STRB_WIDTH-1:0] mask_q;
    logic [1:0]            len_q;
    logic [2:0]            size_q;
    logic [CNT_WIDTH-1:0]  cnt_q;

    logic accept;
    logic aw_fire;
    logic w_fire;
    logic w_last;

    assign accept  = (state_q == S_IDLE) && req_i;
    assign aw_fire = aw_valid_o && aw_ready_i;
    assign w_fire  = w_valid_o && w_ready_i;
    assign w_last  = (cnt_q == len_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: if (req_i) state_d = S_ADDR;
            S_ADDR: if (aw_fire) state_d = S_DATA;
            S_DATA: if (w_fire && w_last) state_d = S_RESP;
            S_RESP: if (b_valid_i) state_d = S_IDLE;   // bresp ignored
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q <= addr_i;
            line_q <= line_i;
            mask_q <= mask_i;
            len_q  <= len_i;
            size_q <= size_i;
        end
    end

    // beat counter, steps on each accepted W beat
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            cnt_q <= '0;
        end else if (accept) begin
            cnt_q <= '0;
        end else if (w_fire && !w_last) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign ready_o    = (state_q == S_IDLE);
    assign aw_valid_o = (state_q == S_ADDR);
    assign w_valid_o  = (state_q == S_DATA);
    assign b_ready_o  = (state_q == S_RESP);

    assign aw_o.addr  = addr_q;
    assign aw_o.len   = {6'd0, len_q};
    assign aw_o.size  = size_q;
    assign aw_o.burst = AXI_BURST_INCR;
    assign aw_o.prot  = AXI_PROT_DATA;
    assign aw_o.id    = AXI_ID;

    assign w_o.data = line_q[cnt_q*DATA_WIDTH +: DATA_WIDTH];   // beat k is bits 64k up
    assign w_o.strb = mask_q;                                   // same mask every beat
    assign w_o.last = w_last;

    // counter must stop at the burst length
    assert property (@(posedge clock) disable iff (!reset)
        state_q != S_IDLE |-> cnt_q <= len_q);

    // W held with the same beat until the slave takes it
    assert property (@(posedge clock) disable iff (!reset)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o));

endmodule

`default_nettype wire

// ==== dcache_axi_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_axi_bridge
    import dcache_axi_pkg::*;
#(
    parameter logic [ID_WIDTH-1:0] AXI_ID = 4'd1
) (
    input  logic                  clock,
    input  logic                  reset,
    // refill requests
    input  logic                  rd_req_i,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    input  logic [1:0]            rd_len_i,
    input  logic [2:0]            rd_size_i,
    output logic                  rd_ready_o,
    output line_t                 rd_line_o,
    output logic                  rd_line_valid_o,
    // write-back requests
    input  logic                  wr_req_i,
    input  logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  line_t                 wr_line_i,
    input  logic [STRB_WIDTH-1:0] wr_mask_i,
    input  logic [1:0]            wr_len_i,
    input  logic [2:0]            wr_size_i,
    output logic                  wr_ready_o,
    // AXI master
    output ar_req_t               ar_o,
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    input  r_beat_t               r_i,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    output aw_req_t               aw_o,
    output logic                  aw_valid_o,
    input  logic                  aw_ready_i,
    output w_beat_t               w_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    input  logic                  b_valid_i,
    output logic                  b_ready_o
);

    r_beat_t rd_beat;
    logic    rd_beat_valid;     // high on each R transfer

    dcache_axi_rd #(
        .AXI_ID(AXI_ID)
    ) u_rd (
        .clock       (clock),
        .reset       (reset),
        .req_i       (rd_req_i),
        .addr_i      (rd_addr_i),
        .len_i       (rd_len_i),
        .size_i      (rd_size_i),
        .ready_o     (rd_ready_o),
        .ar_o        (ar_o),
        .ar_valid_o  (ar_valid_o),
        .ar_ready_i  (ar_ready_i),
        .r_i         (r_i),
        .r_valid_i   (r_valid_i),
        .r_ready_o   (r_ready_o),
        .beat_o      (rd_beat),
        .beat_valid_o(rd_beat_valid)
    );

    dcache_refill_buf u_refill_buf (
        .clock       (clock),
        .reset       (reset),
        .beat_i      (rd_beat),
        .beat_valid_i(rd_beat_valid),
        .line_o      (rd_line_o),
        .line_valid_o(rd_line_valid_o)
    );

    // write path runs on its own, a refill may overlap it
    dcache_axi_wr #(
        .AXI_ID(AXI_ID)
    ) u_wr (
        .clock     (clock),
        .reset     (reset),
        .req_i     (wr_req_i),
        .addr_i    (wr_addr_i),
        .line_i    (wr_line_i),
        .mask_i    (wr_mask_i),
        .len_i     (wr_len_i),
        .size_i    (wr_size_i),
        .ready_o   (wr_ready_o),
        .aw_o      (aw_o),
        .aw_valid_o(aw_valid_o),
        .aw_ready_i(aw_ready_i),
        .w_o       (w_o),
        .w_valid_o (w_valid_o),
        .w_ready_i (w_ready_i),
        .b_valid_i (b_valid_i),
        .b_ready_o (b_ready_o)
    );

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_axi_mem
    import dcache_axi_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic    clock,
    input  ar_req_t ar_i,
    input  logic    ar_valid_i,
    output logic    ar_ready_o,
    output r_beat_t r_o,
    output logic    r_valid_o,
    input  logic    r_ready_i,
    input  aw_req_t aw_i,
    input  logic    aw_valid_i,
    output logic    aw_ready_o,
    input  w_beat_t w_i,
    input  logic    w_valid_i,
    output logic    w_ready_o,
    output logic    b_valid_o,
    input  logic    b_ready_i
);

    localparam int WORD_BITS = $clog2(MEM_WORDS);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 to 3 falling edges, from the top bits of the generator
    task automatic wait_random(inout logic [31:0] seed);
        seed = lcg_next(seed);
        repeat (seed[31:30]) @(negedge clock);
    endtask

    function automatic int word_of(input logic [ADDR_WIDTH-1:0] addr);
        return int'(addr[WORD_BITS+2:3]);   // 8 bytes per word
    endfunction

    // read channel, one burst at a time
    initial begin
        ar_req_t     ar;
        int          word;
        logic [31:0] seed;
        seed       = 32'd36818;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;
        forever begin
            @(negedge clock);
            if (ar_valid_i) begin
                wait_random(seed);
                ar         = ar_i;
                ar_ready_o = 1'b1;
                @(negedge clock);
                ar_ready_o = 1'b0;
                word       = word_of(ar.addr);
                for (int k = 0; k <= int'(ar.len); k++) begin
                    wait_random(seed);
                    r_o.data  = mem[(word + k) % MEM_WORDS];   // INCR, one word per beat
                    r_o.last  = (k == int'(ar.len));
                    r_valid_o = 1'b1;
                    while (!r_ready_i) @(negedge clock);
                    @(negedge clock);
                    r_valid_o = 1'b0;
                end
            end
        end
    end

    // write channel, also owns the memory preset
    initial begin
        aw_req_t     aw;
        int          word;
        logic [31:0] seed;
        seed       = lcg_next(32'd36818);
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 64'(i) ^ 64'hA5A5_0000_0000_0000;
        end
        forever begin
            @(negedge clock);
            if (aw_valid_i) begin
                wait_random(seed);
                aw         = aw_i;
                aw_ready_o = 1'b1;
                @(negedge clock);
                aw_ready_o = 1'b0;
                word       = word_of(aw.addr);
                for (int k = 0; k <= int'(aw.len); k++) begin
                    wait_random(seed);
                    w_ready_o = 1'b1;
                    while (!w_valid_i) @(negedge clock);
                    for (int b = 0; b < STRB_WIDTH; b++) begin
                        if (w_i.strb[b]) begin
                            mem[(word + k) % MEM_WORDS][8*b +: 8] = w_i.data[8*b +: 8];
                        end
                    end
                    @(negedge clock);
                    w_ready_o = 1'b0;
                end
                wait_random(seed);
                b_valid_o = 1'b1;
                while (!b_ready_i) @(negedge clock);
                @(negedge clock);
                b_valid_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_dcache_axi.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dcache_axi
    import dcache_axi_pkg::*;
();

    localparam int MEM_WORDS   = 256;
    localparam int CLK_PERIOD  = 40;
    localparam int WATCHDOG_NS = 6 * 64 * 8 * CLK_PERIOD;   // tests x transfers x cycles

    logic                  clock;
    logic                  reset;
    logic                  rd_req, rd_ready, rd_line_valid;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [1:0]            rd_len;
    logic [2:0]            rd_size;
    line_t                 rd_line;
    logic                  wr_req, wr_ready;
    logic [ADDR_WIDTH-1:0] wr_addr;
    line_t                 wr_line;
    logic [STRB_WIDTH-1:0] wr_mask;
    logic [1:0]            wr_len;
    logic [2:0]            wr_size;
    ar_req_t               ar;
    aw_req_t               aw;
    r_beat_t               r;
    w_beat_t               w;
    logic                  ar_valid, ar_ready, r_valid, r_ready;
    logic                  aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;

    logic [DATA_WIDTH-1:0] mirror [MEM_WORDS];
    line_t                 exp_line;
    logic [1:0]            exp_wr_len;
    logic [2:0]            w_cnt;      // W beats since the last AW
    int                    errors, errors_at_start, tests_run, tests_failed;

    dcache_axi_bridge #(
        .AXI_ID(4'd1)
    ) UUT (
        .clock(clock), .reset(reset),
        .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_len_i(rd_len), .rd_size_i(rd_size),
        .rd_ready_o(rd_ready), .rd_line_o(rd_line), .rd_line_valid_o(rd_line_valid),
        .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_line_i(wr_line), .wr_mask_i(wr_mask),
        .wr_len_i(wr_len), .wr_size_i(wr_size), .wr_ready_o(wr_ready),
        .ar_o(ar), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
        .r_i(r), .r_valid_i(r_valid), .r_ready_o(r_ready),
        .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
        .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
        .b_valid_i(b_valid), .b_ready_o(b_ready)
    );

    tb_axi_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) u_mem (
        .clock(clock),
        .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready),
        .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_valid_o(b_valid), .b_ready_i(b_ready)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_cnt <= 3'd0;
        end else if (aw_valid && aw_ready) begin
            w_cnt <= 3'd0;
        end else if (w_valid && w_ready) begin
            w_cnt <= w_cnt + 3'd1;
        end
    end

    // valid and ready low toward AXI, both cache-side readies high
    assert property (@(posedge clock) !reset |->
        {ar_valid, aw_valid, w_valid, r_ready, b_ready, rd_line_valid, rd_ready, wr_ready}
        == 8'b0000_0011)
        else begin
            $display("[FAIL] {ar_valid_o..wr_ready_o} = %h, expected 03", $sampled({ar_valid,
                aw_valid, w_valid, r_ready, b_ready, rd_line_valid, rd_ready, wr_ready}));
            errors++;
        end

    assert property (@(posedge clock) disable iff (!reset)
        rd_line_valid |-> rd_line == exp_line)
        else begin
            $display("[FAIL] rd_line_o = %h, expected %h", $sampled(rd_line), exp_line);
            errors++;
        end

    assert property (@(posedge clock) disable iff (!reset)
        w_valid && w_ready |-> w.last == (w_cnt == {1'b0, exp_wr_len}))
        else begin
            $display("[FAIL] w_o.last = %h on beat %h, burst len %h", $sampled(w.last),
                $sampled(w_cnt), exp_wr_len);
            errors++;
        end

    // address payloads stay put while the slave stalls
    assert property (@(posedge clock) disable iff (!reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin
            $display("[FAIL] ar_o = %h, was %h before", $sampled(ar), $past(ar));
            errors++;
        end

    assert property (@(posedge clock) disable iff (!reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else begin
            $display("[FAIL] aw_o = %h, was %h before", $sampled(aw), $past(aw));
            errors++;
        end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the DUT did not finish its transfers in time");
        $display("Something failed");
        $finish;
    end

    task automatic refill(input logic [ADDR_WIDTH-1:0] addr, input logic [1:0] len);
        int word;
        while (!rd_ready) @(negedge clock);
        word = int'(addr[10:3]);
        for (int k = 0; k <= int'(len); k++) begin
            exp_line[k*DATA_WIDTH +: DATA_WIDTH] = mirror[(word + k) % MEM_WORDS];
        end
        rd_addr = addr;
        rd_len  = len;
        rd_size = 3'd3;
        rd_req  = 1'b1;
        @(negedge clock);
        rd_req = 1'b0;
        do @(negedge clock); while (!rd_line_valid);
        @(negedge clock);   // line check fires on this edge
    endtask

    task automatic write_back(input logic [ADDR_WIDTH-1:0] addr, input line_t line,
                              input logic [STRB_WIDTH-1:0] mask, input logic [1:0] len);
        int word;
        while (!wr_ready) @(negedge clock);
        word = int'(addr[10:3]);
        for (int k = 0; k <= int'(len); k++) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (mask[b]) begin
                    mirror[(word + k) % MEM_WORDS][8*b +: 8] = line[k*DATA_WIDTH + 8*b +: 8];
                end
            end
        end
        wr_addr    = addr;
        wr_line    = line;
        wr_mask    = mask;
        wr_len     = len;
        wr_size    = 3'd3;
        exp_wr_len = len;
        wr_req     = 1'b1;
        @(negedge clock);
        wr_req = 1'b0;
        do @(negedge clock); while (!wr_ready);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        errors_at_start = errors;
    endtask

    initial begin
        rd_req = 1'b0;
        rd_addr = '0;
        rd_len = 2'd0;
        rd_size = 3'd0;
        wr_req = 1'b0;
        wr_addr = '0;
        wr_line = '0;
        wr_mask = '0;
        wr_len = 2'd0;
        wr_size = 3'd0;
        exp_line = '0;
        exp_wr_len = 2'd0;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mirror[i] = 64'(i) ^ 64'hA5A5_0000_0000_0000;   // same preset as the slave
        end
        reset = 1'b0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        report_test("reset state");

        refill(64'h100, 2'd3);
        report_test("full-line refill");

        write_back(64'h200, {64'h0123_4567_89ab_cdef, 64'hfeed_face_cafe_beef,
                             64'h1111_2222_3333_4444, 64'h5555_6666_7777_8888}, 8'hff, 2'd3);
        refill(64'h200, 2'd3);
        report_test("write-back then refill");

        write_back(64'h300, {4{64'hdead_beef_0bad_f00d}}, 8'h3c, 2'd1);   // bytes 2 to 5
        refill(64'h300, 2'd3);
        report_test("partial write");

        fork
            refill(64'h400, 2'd3);
            write_back(64'h500, {64'h0f0f_0f0f_0f0f_0f0f, 64'h7777_0000_7777_0000,
                                 64'h9999_aaaa_bbbb_cccc, 64'h1234_5678_9abc_def0}, 8'hff, 2'd3);
        join
        refill(64'h500, 2'd3);
        report_test("overlap under back-pressure");

        refill(64'h600, 2'd1);   // slots 2 and 3 keep the previous line
        report_test("short refill");

        $display("tests %0d, failed %0d, assertion errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
dcache_axi_pkg.sv
dcache_axi_rd.sv
dcache_refill_buf.sv
dcache_axi_wr.sv
dcache_axi_bridge.sv
tb_axi_mem.sv
tb_dcache_axi.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f all.f --top-module tb_dcache_axi \
    -Mdir obj_dir -o sim_dcache_axi \
    && ./obj_dir/sim_dcache_axi > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^Everything OK$" sim.log && exit 0 || exit 1
